/* pcie_tx_pkg.sv */
// shared sizes, enums and bus structs for the pcie dma transmit path
// referenced by scoped name from every rtl file

package pcie_tx_pkg;

   localparam int NUM_CHANNELS = 4;
   localparam int CHAN_BITS    = 2;
   localparam int BURST_BEATS  = 16;   // 64-bit beats per write burst
   localparam int BEAT_BITS    = 4;
   localparam int READ_DWORDS  = 128;
   localparam int WRITE_DWORDS = 32;
   localparam int READ_STEP    = 512;  // bytes between read requests
   localparam int WRITE_STEP   = 128;  // bytes between write bursts
   localparam int FIFO_DEPTH   = 32;
   localparam int FIFO_AW      = 5;
   localparam int FIFO_SPACE   = 18;   // longest tlp in beats

   // completion with data, 1 dword, fixed header
   localparam logic [31:0] CPL_DW0 = 32'h4A00_0001;

   typedef enum logic
   {
      CMD_READ,
      CMD_WRITE
   } cmd_op_t;

   typedef enum logic
   {
      REQ_READ,
      REQ_WRITE
   } req_kind_t;

   typedef struct packed
   {
      logic [CHAN_BITS-1:0] channel;
      cmd_op_t              op;
      logic [63:0]          addr;
      logic [7:0]           count;  // requests or bursts
   } dma_cmd_t;

   typedef struct packed
   {
      req_kind_t   kind;
      logic [63:0] addr;
      logic [7:0]  tag;   // channel in 7:6, sequence in 2:0
   } dma_req_t;

   typedef struct packed
   {
      logic [31:0] dw2;
      logic [31:0] data;
   } rc_req_t;

   typedef struct packed
   {
      logic        one_dw;
      logic        last;
      logic [63:0] data;
   } tx_beat_t;

   typedef enum logic [2:0]
   {
      IDLE,
      RC_HDR,
      RC_DATA,
      RR_HDR,
      RR_ADDR,
      WR_HDR,
      WR_ADDR,
      WR_DATA
   } fmt_state_t;

endpackage

/* dma_cmd_demux.sv */
// steers host commands to the addressed dma channel
// a command for a busy channel is dropped and flagged

`timescale 1ns/1ps

module dma_cmd_demux
(
   input  logic                                  clock,
   input  logic                                  reset,
   input  pcie_tx_pkg::dma_cmd_t                 i_cmd,
   input  logic                                  i_cmd_valid,
   input  logic [pcie_tx_pkg::NUM_CHANNELS-1:0]  i_busy,
   output pcie_tx_pkg::dma_cmd_t                 o_chan_cmd,
   output logic [pcie_tx_pkg::NUM_CHANNELS-1:0]  o_chan_load,
   output logic                                  o_cmd_error
);

   logic [pcie_tx_pkg::NUM_CHANNELS-1:0] chan_busy;

   // a load still in flight counts as busy
   assign chan_busy = i_busy | o_chan_load;

   always_ff @(posedge clock)
   begin
      o_chan_cmd <= i_cmd;
      if (reset)
      begin
         o_chan_load <= '0;
         o_cmd_error <= 1'b0;
      end
      else
      begin
         o_chan_load <= '0;
         o_cmd_error <= i_cmd_valid && chan_busy[i_cmd.channel];
         if (i_cmd_valid && !chan_busy[i_cmd.channel])
            o_chan_load[i_cmd.channel] <= 1'b1;
      end
   end

endmodule

/* dma_channel.sv */
// one dma channel, expands a loaded command into a run of read
// requests or write bursts and counts the data beats of each burst

`timescale 1ns/1ps

module dma_channel
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  i_load,
   input  pcie_tx_pkg::dma_cmd_t i_cmd,
   input  logic                  i_accept,
   input  logic                  i_take,
   output logic                  o_busy,
   output logic                  o_req_valid,
   output pcie_tx_pkg::dma_req_t o_req,
   output logic                  o_last
);

   logic [63:0]                       addr;
   logic [7:0]                        count;     // requests still to issue
   logic [2:0]                        seq;
   logic [pcie_tx_pkg::CHAN_BITS-1:0] chan;
   pcie_tx_pkg::cmd_op_t              op;
   logic                              in_burst;  // write data phase
   logic [pcie_tx_pkg::BEAT_BITS-1:0] beat;

   assign o_busy = (count != 8'd0) || in_burst;
   assign o_last = in_burst && (&beat);  // 16th beat of the burst
   assign o_req = '{kind: (op == pcie_tx_pkg::CMD_WRITE) ? pcie_tx_pkg::REQ_WRITE
                                                          : pcie_tx_pkg::REQ_READ,
                    addr: addr,
                    tag:  {chan, 3'b000, seq}};

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         count       <= 8'd0;
         seq         <= 3'd0;
         o_req_valid <= 1'b0;
         in_burst    <= 1'b0;
         beat        <= '0;
      end
      else if (i_load)
      begin
         count       <= i_cmd.count;
         seq         <= 3'd0;
         o_req_valid <= i_cmd.count != 8'd0;
      end
      else
      begin
         if (i_accept)
         begin
            count       <= count - 8'd1;
            seq         <= seq + 3'd1;
            o_req_valid <= 1'b0;
            in_burst    <= op == pcie_tx_pkg::CMD_WRITE;
         end
         else if (!o_req_valid && !in_burst && count != 8'd0)
            o_req_valid <= 1'b1;  // next request of the run
         if (i_take)
         begin
            beat <= beat + 1'b1;  // wraps to zero after the last beat
            if (o_last)
               in_burst <= 1'b0;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (i_load)
      begin
         addr <= i_cmd.addr;
         chan <= i_cmd.channel;
         op   <= i_cmd.op;
      end
      else if (i_accept)
      begin
         if (op == pcie_tx_pkg::CMD_WRITE)
            addr <= addr + 64'(pcie_tx_pkg::WRITE_STEP);
         else
            addr <= addr + 64'(pcie_tx_pkg::READ_STEP);
      end
   end

endmodule

/* request_arbiter.sv */
// round-robin arbiter between the dma channels and the tlp formatter
// a write grant is held through the data beats of its burst

`timescale 1ns/1ps

module request_arbiter
(
   input  logic                                              clock,
   input  logic                                              reset,
   input  logic [pcie_tx_pkg::NUM_CHANNELS-1:0]              i_req_valid,
   input  pcie_tx_pkg::dma_req_t [pcie_tx_pkg::NUM_CHANNELS-1:0] i_req,
   input  logic [pcie_tx_pkg::NUM_CHANNELS-1:0]              i_last,
   input  logic [pcie_tx_pkg::NUM_CHANNELS-1:0][63:0]        i_wr_data,
   output logic [pcie_tx_pkg::NUM_CHANNELS-1:0]              o_accept,
   output logic [pcie_tx_pkg::NUM_CHANNELS-1:0]              o_take,
   output logic                                              o_req_valid,
   output pcie_tx_pkg::dma_req_t                             o_req,
   output logic [63:0]                                       o_wr_data,
   output logic                                              o_wr_last,
   input  logic                                              i_fmt_accept,
   input  logic                                              i_fmt_beat
);

   logic [pcie_tx_pkg::CHAN_BITS-1:0] grant;      // last granted channel
   logic [pcie_tx_pkg::CHAN_BITS-1:0] pick;
   logic                              pick_found;
   logic                              wr_active;  // write burst in progress
   logic                              idle;

   assign idle      = !o_req_valid && !wr_active;
   assign o_wr_data = i_wr_data[grant];
   assign o_wr_last = i_last[grant];

   // search starts at the channel after the last grant
   always_comb
   begin
      logic [pcie_tx_pkg::CHAN_BITS-1:0] idx;
      pick       = grant;
      pick_found = 1'b0;
      idx        = grant;
      for (int i = 1; i <= pcie_tx_pkg::NUM_CHANNELS; i++)
      begin
         idx = grant + i[pcie_tx_pkg::CHAN_BITS-1:0];
         if (!pick_found && i_req_valid[idx])
         begin
            pick       = idx;
            pick_found = 1'b1;
         end
      end
   end

   always_comb
   begin
      o_accept        = '0;
      o_take          = '0;
      o_accept[grant] = i_fmt_accept && o_req_valid;
      o_take[grant]   = i_fmt_beat && wr_active;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         grant       <= '1;  // channel 0 goes first
         o_req_valid <= 1'b0;
         wr_active   <= 1'b0;
      end
      else if (o_req_valid)
      begin
         if (i_fmt_accept)
         begin
            o_req_valid <= 1'b0;
            wr_active   <= o_req.kind == pcie_tx_pkg::REQ_WRITE;
         end
      end
      else if (wr_active)
      begin
         if (i_fmt_beat && i_last[grant])
            wr_active <= 1'b0;
      end
      else if (pick_found)
      begin
         grant       <= pick;
         o_req_valid <= 1'b1;
      end
   end

   always_ff @(posedge clock)
   begin
      if (idle && pick_found)
         o_req <= i_req[pick];
   end

endmodule

/* tlp_formatter.sv */
// builds completion, read request and write request tlps as 64-bit beats
// one beat is written to the output fifo the cycle after each state

`timescale 1ns/1ps

module tlp_formatter
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic [15:0]           i_pci_id,
   input  pcie_tx_pkg::rc_req_t  i_rc,
   input  logic                  i_rc_valid,
   output logic                  o_rc_ready,
   input  logic                  i_req_valid,
   input  pcie_tx_pkg::dma_req_t i_req,
   input  logic [63:0]           i_wr_data,
   input  logic                  i_wr_last,
   output logic                  o_accept,
   output logic                  o_beat,
   output pcie_tx_pkg::tx_beat_t o_fifo_data,
   output logic                  o_fifo_valid,
   input  logic                  i_fifo_space
);

   pcie_tx_pkg::fmt_state_t state;
   logic                    is_32;    // 3-dword header
   logic                    wr_done;  // final word taken, one beat left
   logic [63:0]             data_q;   // word before the current one
   logic                    req_is_32;
   logic [31:0]             hdr_dw1;

   function automatic logic [31:0] byte_swap(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   assign req_is_32  = i_req.addr[63:32] == 32'd0;
   assign hdr_dw1    = {i_pci_id, i_req.tag, 8'hFF};
   assign o_rc_ready = state == pcie_tx_pkg::RC_HDR;
   assign o_accept   = (state == pcie_tx_pkg::RR_HDR) || (state == pcie_tx_pkg::WR_HDR);
   assign o_beat     = (state == pcie_tx_pkg::WR_ADDR)
                    || (state == pcie_tx_pkg::WR_DATA && !wr_done);

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state        <= pcie_tx_pkg::IDLE;
         wr_done      <= 1'b0;
         o_fifo_valid <= 1'b0;
      end
      else
      begin
         o_fifo_valid <= state != pcie_tx_pkg::IDLE;
         wr_done      <= (state == pcie_tx_pkg::WR_DATA) && o_beat && i_wr_last;
         case (state)
            pcie_tx_pkg::IDLE:
               if (i_fifo_space)  // room for a whole tlp
               begin
                  if (i_rc_valid)
                     state <= pcie_tx_pkg::RC_HDR;
                  else if (i_req_valid && i_req.kind == pcie_tx_pkg::REQ_READ)
                     state <= pcie_tx_pkg::RR_HDR;
                  else if (i_req_valid)
                     state <= pcie_tx_pkg::WR_HDR;
               end
            pcie_tx_pkg::RC_HDR:  state <= pcie_tx_pkg::RC_DATA;
            pcie_tx_pkg::RR_HDR:  state <= pcie_tx_pkg::RR_ADDR;
            pcie_tx_pkg::WR_HDR:  state <= pcie_tx_pkg::WR_ADDR;
            pcie_tx_pkg::WR_ADDR: state <= pcie_tx_pkg::WR_DATA;
            pcie_tx_pkg::WR_DATA:
               if (wr_done)
                  state <= pcie_tx_pkg::IDLE;
            default:              state <= pcie_tx_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      data_q <= i_wr_data;
      if (o_accept)
         is_32 <= req_is_32;
      case (state)
         pcie_tx_pkg::RC_HDR:
            o_fifo_data <= {2'b00, i_pci_id, 16'd4, pcie_tx_pkg::CPL_DW0};
         pcie_tx_pkg::RC_DATA:
            o_fifo_data <= {2'b01, byte_swap(i_rc.data), i_rc.dw2};
         pcie_tx_pkg::RR_HDR:
            o_fifo_data <= {2'b00, hdr_dw1, 2'b00, !req_is_32,
                            29'(pcie_tx_pkg::READ_DWORDS)};
         pcie_tx_pkg::RR_ADDR:
            if (is_32)
               o_fifo_data <= {2'b11, 32'd0, i_req.addr[31:0]};  // odd dword count
            else
               o_fifo_data <= {2'b01, i_req.addr[31:0], i_req.addr[63:32]};
         pcie_tx_pkg::WR_HDR:
            o_fifo_data <= {2'b00, hdr_dw1, 2'b01, !req_is_32,
                            29'(pcie_tx_pkg::WRITE_DWORDS)};
         pcie_tx_pkg::WR_ADDR:
            if (is_32)
               o_fifo_data <= {2'b00, byte_swap(i_wr_data[31:0]), i_req.addr[31:0]};
            else
               o_fifo_data <= {2'b00, i_req.addr[31:0], i_req.addr[63:32]};
         pcie_tx_pkg::WR_DATA:
            // a 3-dword header shifts the payload up by one dword
            if (is_32)
               o_fifo_data <= {wr_done, wr_done,
                               wr_done ? 32'd0 : byte_swap(i_wr_data[31:0]),
                               byte_swap(data_q[63:32])};
            else
               o_fifo_data <= {1'b0, wr_done, byte_swap(data_q[63:32]),
                               byte_swap(data_q[31:0])};
         default:
            o_fifo_data <= '0;
      endcase
   end

endmodule

/* fwft_fifo.sv */
// first-word-fall-through fifo for formatted tx beats
// o_space says a full tlp still fits, counting a write in flight

`timescale 1ns/1ps

module fwft_fifo
(
   input  logic                  clock,
   input  logic                  reset,
   input  pcie_tx_pkg::tx_beat_t i_data,
   input  logic                  i_valid,
   output logic                  o_space,
   output pcie_tx_pkg::tx_beat_t o_data,
   output logic                  o_valid,
   input  logic                  i_read
);

   pcie_tx_pkg::tx_beat_t           mem [pcie_tx_pkg::FIFO_DEPTH];
   logic [pcie_tx_pkg::FIFO_AW-1:0] wr_ptr;
   logic [pcie_tx_pkg::FIFO_AW-1:0] rd_ptr;
   logic [pcie_tx_pkg::FIFO_AW:0]   count;
   logic                            do_read;

   assign do_read = i_read && o_valid;
   assign o_valid = count != '0;
   assign o_data  = mem[rd_ptr];  // head visible without a read
   assign o_space = (count + {{pcie_tx_pkg::FIFO_AW{1'b0}}, i_valid})
                    <= (pcie_tx_pkg::FIFO_DEPTH - pcie_tx_pkg::FIFO_SPACE);

   always_ff @(posedge clock)
   begin
      if (i_valid)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (i_valid)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;
         if (i_valid && !do_read)
            count <= count + 1'b1;
         else if (!i_valid && do_read)
            count <= count - 1'b1;
      end
   end

endmodule

/* pcie_tx_top.sv */
// transmit side of the pcie dma bridge
// command demux, dma channels, arbiter, tlp formatter and output fifo

`timescale 1ns/1ps

module pcie_tx_top
(
   input  logic                                        clock,
   input  logic                                        reset,
   input  pcie_tx_pkg::dma_cmd_t                       i_cmd,
   input  logic                                        i_cmd_valid,
   output logic                                        o_cmd_error,
   output logic [pcie_tx_pkg::NUM_CHANNELS-1:0]        o_busy,
   input  logic [15:0]                                 i_pci_id,
   input  pcie_tx_pkg::rc_req_t                        i_rc,
   input  logic                                        i_rc_valid,
   output logic                                        o_rc_ready,
   input  logic [pcie_tx_pkg::NUM_CHANNELS-1:0][63:0]  i_wr_data,
   output logic [pcie_tx_pkg::NUM_CHANNELS-1:0]        o_wr_take,
   output pcie_tx_pkg::tx_beat_t                       o_tx,
   output logic                                        o_tx_valid,
   input  logic                                        i_tx_ready
);

   pcie_tx_pkg::dma_cmd_t                                 chan_cmd;
   logic [pcie_tx_pkg::NUM_CHANNELS-1:0]                  chan_load;
   logic [pcie_tx_pkg::NUM_CHANNELS-1:0]                  req_valid;
   logic [pcie_tx_pkg::NUM_CHANNELS-1:0]                  req_last;
   logic [pcie_tx_pkg::NUM_CHANNELS-1:0]                  req_accept;
   pcie_tx_pkg::dma_req_t [pcie_tx_pkg::NUM_CHANNELS-1:0] chan_req;
   logic                                                  arb_valid;
   pcie_tx_pkg::dma_req_t                                 arb_req;
   logic [63:0]                                           arb_data;
   logic                                                  arb_last;
   logic                                                  fmt_accept;
   logic                                                  fmt_beat;
   pcie_tx_pkg::tx_beat_t                                 fifo_data;
   logic                                                  fifo_valid;
   logic                                                  fifo_space;

   dma_cmd_demux u_demux
   (
      .clock       (clock),
      .reset       (reset),
      .i_cmd       (i_cmd),
      .i_cmd_valid (i_cmd_valid),
      .i_busy      (o_busy),
      .o_chan_cmd  (chan_cmd),
      .o_chan_load (chan_load),
      .o_cmd_error (o_cmd_error)
   );

   for (genvar c = 0; c < pcie_tx_pkg::NUM_CHANNELS; c++)
   begin : g_chan
      dma_channel u_chan
      (
         .clock       (clock),
         .reset       (reset),
         .i_load      (chan_load[c]),
         .i_cmd       (chan_cmd),
         .i_accept    (req_accept[c]),
         .i_take      (o_wr_take[c]),
         .o_busy      (o_busy[c]),
         .o_req_valid (req_valid[c]),
         .o_req       (chan_req[c]),
         .o_last      (req_last[c])
      );
   end

   request_arbiter u_arbiter
   (
      .clock        (clock),
      .reset        (reset),
      .i_req_valid  (req_valid),
      .i_req        (chan_req),
      .i_last       (req_last),
      .i_wr_data    (i_wr_data),
      .o_accept     (req_accept),
      .o_take       (o_wr_take),
      .o_req_valid  (arb_valid),
      .o_req        (arb_req),
      .o_wr_data    (arb_data),
      .o_wr_last    (arb_last),
      .i_fmt_accept (fmt_accept),
      .i_fmt_beat   (fmt_beat)
   );

   tlp_formatter u_formatter
   (
      .clock        (clock),
      .reset        (reset),
      .i_pci_id     (i_pci_id),
      .i_rc         (i_rc),
      .i_rc_valid   (i_rc_valid),
      .o_rc_ready   (o_rc_ready),
      .i_req_valid  (arb_valid),
      .i_req        (arb_req),
      .i_wr_data    (arb_data),
      .i_wr_last    (arb_last),
      .o_accept     (fmt_accept),
      .o_beat       (fmt_beat),
      .o_fifo_data  (fifo_data),
      .o_fifo_valid (fifo_valid),
      .i_fifo_space (fifo_space)
   );

   fwft_fifo u_fifo
   (
      .clock   (clock),
      .reset   (reset),
      .i_data  (fifo_data),
      .i_valid (fifo_valid),
      .o_space (fifo_space),
      .o_data  (o_tx),
      .o_valid (o_tx_valid),
      .i_read  (i_tx_ready)
   );

endmodule

/* tb_tlp_model.svh */
// reference model of the tx tlp stream, included inside the testbench
// builds the dword list of each tlp and packs it into expected beats

`ifndef TB_TLP_MODEL_SVH
`define TB_TLP_MODEL_SVH

typedef logic [31:0] dword_q_t [$];
typedef pcie_tx_pkg::tx_beat_t beat_q_t [$];

function automatic logic [31:0] reverse_bytes(input logic [31:0] x);
   return {x[7:0], x[15:8], x[23:16], x[31:24]};
endfunction

// dword 2k low, dword 2k+1 high, odd tail flagged one_dw
function automatic beat_q_t pack_beats(input dword_q_t dws);
   beat_q_t               beats;
   pcie_tx_pkg::tx_beat_t b;
   for (int k = 0; 2 * k < dws.size(); k++)
   begin
      b.data[31:0]  = dws[2 * k];
      b.data[63:32] = (2 * k + 1 < dws.size()) ? dws[2 * k + 1] : 32'd0;
      b.last        = (2 * k + 2 >= dws.size());
      b.one_dw      = b.last && (dws.size() % 2 == 1);
      beats.push_back(b);
   end
   return beats;
endfunction

function automatic dword_q_t completion_tlp(input logic [15:0] pci_id,
                                            input pcie_tx_pkg::rc_req_t rc);
   dword_q_t dws;
   dws.push_back(pcie_tx_pkg::CPL_DW0);
   dws.push_back({pci_id, 16'd4});  // byte count 4
   dws.push_back(rc.dw2);
   dws.push_back(reverse_bytes(rc.data));
   return dws;
endfunction

// fmt bits 31:29 are {0, write, 4dw}, length in 9:0
function automatic dword_q_t header_dwords(input logic write, input int len,
                                           input logic [15:0] pci_id,
                                           input logic [63:0] addr, input logic [7:0] tag);
   dword_q_t dws;
   logic     four_dw;
   four_dw = addr[63:32] != 32'd0;
   dws.push_back({1'b0, write, four_dw, 19'd0, len[9:0]});
   dws.push_back({pci_id, tag, 8'hFF});
   if (four_dw)
      dws.push_back(addr[63:32]);
   dws.push_back(addr[31:0]);
   return dws;
endfunction

function automatic dword_q_t read_tlp(input logic [15:0] pci_id, input logic [63:0] addr,
                                      input logic [7:0] tag);
   return header_dwords(1'b0, pcie_tx_pkg::READ_DWORDS, pci_id, addr, tag);
endfunction

function automatic dword_q_t write_tlp(input logic [15:0] pci_id, input logic [63:0] addr,
                                       input logic [7:0] tag,
                                       input logic [63:0] words [pcie_tx_pkg::BURST_BEATS]);
   dword_q_t dws;
   dws = header_dwords(1'b1, 2 * pcie_tx_pkg::BURST_BEATS, pci_id, addr, tag);
   foreach (words[w])
   begin
      dws.push_back(reverse_bytes(words[w][31:0]));
      dws.push_back(reverse_bytes(words[w][63:32]));
   end
   return dws;
endfunction

`endif

/* tb_pcie_tx_top.sv */
// testbench for the pcie dma transmit path
// drives commands, completions and write data, and checks every tx beat
// against the reference model, with random tx ready in the last phase

`timescale 1ns/1ps

module tb_pcie_tx_top;

   localparam int          NUM_SRC = pcie_tx_pkg::NUM_CHANNELS + 1;  // channels plus completions
   localparam int          RC_SRC  = pcie_tx_pkg::NUM_CHANNELS;
   localparam logic [15:0] PCI_ID  = 16'h01A0;
   localparam int          LIMIT   = 20000;

   typedef logic [pcie_tx_pkg::NUM_CHANNELS-1:0] chan_bits_t;

   logic                                       clock;
   logic                                       reset;
   pcie_tx_pkg::dma_cmd_t                      cmd;
   logic                                       cmd_valid;
   logic                                       cmd_error;
   chan_bits_t                                 busy;
   logic [15:0]                                pci_id;
   pcie_tx_pkg::rc_req_t                       rc;
   logic                                       rc_valid;
   logic                                       rc_ready;
   logic [pcie_tx_pkg::NUM_CHANNELS-1:0][63:0] wr_data;
   chan_bits_t                                 wr_take;
   pcie_tx_pkg::tx_beat_t                      tx;
   logic                                       tx_valid;
   logic                                       tx_ready;

   pcie_tx_pkg::tx_beat_t exp_q [NUM_SRC][$];
   pcie_tx_pkg::tx_beat_t got_q [$];
   int                    cur_src = -1;  // source of the tlp in flight
   int                    take_count [pcie_tx_pkg::NUM_CHANNELS];
   int                    planned_takes [pcie_tx_pkg::NUM_CHANNELS];
   chan_bits_t            take_seen;
   int                    rc_pulses;
   logic                  random_ready;
   int                    seed = 32'hdc37_f08a;

   `include "tb_tlp_model.svh"

   pcie_tx_top dut
   (
      .clock       (clock),
      .reset       (reset),
      .i_cmd       (cmd),
      .i_cmd_valid (cmd_valid),
      .o_cmd_error (cmd_error),
      .o_busy      (busy),
      .i_pci_id    (pci_id),
      .i_rc        (rc),
      .i_rc_valid  (rc_valid),
      .o_rc_ready  (rc_ready),
      .i_wr_data   (wr_data),
      .o_wr_take   (wr_take),
      .o_tx        (tx),
      .o_tx_valid  (tx_valid),
      .i_tx_ready  (tx_ready)
   );

   always #5 clock = ~clock;

   // payload word n of a channel
   function automatic logic [63:0] make_word(input int chan, input int n);
      return {8'hA0 + 8'(chan), 8'(n), 16'(n * 7 + chan),
              32'h1234_5678 ^ 32'(n << 4) ^ 32'(chan)};
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_beat(input string name, input pcie_tx_pkg::tx_beat_t got,
                             input pcie_tx_pkg::tx_beat_t exp);
      if (got !== exp)
         fail_now($sformatf("Fail t=%0t %s: got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_bits(input string name, input chan_bits_t got, input chan_bits_t exp);
      if (got !== exp)
         fail_now($sformatf("Fail t=%0t %s: got %b expected %b", $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
         fail_now($sformatf("Fail t=%0t %s: got %0d expected %0d", $time, name, got, exp));
   endtask

   // tx consumer, write data source and completion handshake
   always @(negedge clock)
   begin
      if (!reset)
      begin
         for (int c = 0; c < pcie_tx_pkg::NUM_CHANNELS; c++)
         begin
            if (take_seen[c])
               take_count[c]++;
            take_seen[c] = wr_take[c];  // consumed at the coming edge
            wr_data[c]   = make_word(c, take_count[c]);
         end
         if (rc_ready)
         begin
            rc_pulses++;
            rc_valid = 1'b0;
         end
         tx_ready = random_ready ? 1'($random(seed)) : 1'b1;
         if (tx_valid && tx_ready)
            got_q.push_back(tx);
      end
   end

   // beats of one tlp must come from one source in order
   always @(posedge clock)
   begin : compare_beats
      pcie_tx_pkg::tx_beat_t got;
      int                    src;
      while (got_q.size() > 0)
      begin
         got = got_q.pop_front();
         if (cur_src < 0)
         begin
            src = -1;
            for (int s = 0; s < NUM_SRC; s++)
               if (src < 0 && exp_q[s].size() > 0 && exp_q[s][0] === got)
                  src = s;
            if (src < 0)
               fail_now($sformatf("o_tx beat %h at t=%0t starts no expected TLP", got, $time));
            else
               cur_src = src;
         end
         check_beat("o_tx", got, exp_q[cur_src].pop_front());
         if (got.last)
            cur_src = -1;
      end
   end

   task automatic expect_cmd(input int chan, input logic write, input logic [63:0] addr,
                             input int count);
      logic [63:0] words [pcie_tx_pkg::BURST_BEATS];
      beat_q_t     beats;
      logic [7:0]  tag;
      for (int i = 0; i < count; i++)
      begin
         tag = {2'(chan), 3'b000, 3'(i)};
         if (write)
         begin
            foreach (words[w])
               words[w] = make_word(chan, planned_takes[chan] + w);
            planned_takes[chan] += pcie_tx_pkg::BURST_BEATS;
            beats = pack_beats(write_tlp(PCI_ID, addr + 64'(i * pcie_tx_pkg::WRITE_STEP),
                                         tag, words));
         end
         else
            beats = pack_beats(read_tlp(PCI_ID, addr + 64'(i * pcie_tx_pkg::READ_STEP), tag));
         foreach (beats[k])
            exp_q[chan].push_back(beats[k]);
      end
   endtask

   task automatic send_cmd(input int chan, input logic write, input logic [63:0] addr,
                           input int count, input logic busy_error);
      chan_bits_t mask;
      mask = chan_bits_t'(1 << chan);
      if (!busy_error)
         expect_cmd(chan, write, addr, count);
      @(negedge clock);
      cmd.channel = 2'(chan);
      cmd.op      = write ? pcie_tx_pkg::CMD_WRITE : pcie_tx_pkg::CMD_READ;
      cmd.addr    = addr;
      cmd.count   = 8'(count);
      cmd_valid   = 1'b1;
      @(negedge clock);
      cmd_valid = 1'b0;
      check_bits("o_cmd_error", chan_bits_t'(cmd_error), chan_bits_t'(busy_error));
      @(negedge clock);
      check_bits("o_busy", busy & mask, mask);  // channel holds a job now
   endtask

   task automatic send_rc(input logic [31:0] dw2, input logic [31:0] data);
      beat_q_t beats;
      int      n;
      rc.dw2  = dw2;
      rc.data = data;
      beats   = pack_beats(completion_tlp(PCI_ID, rc));
      foreach (beats[k])
         exp_q[RC_SRC].push_back(beats[k]);
      @(negedge clock);
      rc_valid = 1'b1;
      n        = 0;
      while (rc_valid)
      begin
         @(negedge clock);
         n++;
         if (n > LIMIT)
            fail_now("timeout waiting for o_rc_ready");
      end
   endtask

   function automatic logic all_done();
      logic done;
      done = (busy == '0) && !tx_valid && !rc_valid && (got_q.size() == 0);
      for (int s = 0; s < NUM_SRC; s++)
         done = done && (exp_q[s].size() == 0);
      return done;
   endfunction

   task automatic wait_idle(input string phase);
      int n;
      n = 0;
      while (!all_done())
      begin
         @(negedge clock);
         n++;
         if (n > LIMIT)
            fail_now({"timeout in ", phase, ", expected beats never appeared or o_busy stuck"});
      end
      for (int c = 0; c < pcie_tx_pkg::NUM_CHANNELS; c++)
         check_count($sformatf("o_wr_take pulses ch%0d", c), take_count[c], planned_takes[c]);
   endtask

   initial
   begin
      clock        = 1'b0;
      reset        = 1'b1;
      cmd          = '0;
      cmd_valid    = 1'b0;
      pci_id       = PCI_ID;
      rc           = '0;
      rc_valid     = 1'b0;
      tx_ready     = 1'b1;
      take_seen    = '0;
      rc_pulses    = 0;
      random_ready = 1'b0;
      for (int c = 0; c < pcie_tx_pkg::NUM_CHANNELS; c++)
      begin
         take_count[c]    = 0;
         planned_takes[c] = 0;
         wr_data[c]       = make_word(c, 0);
      end
      repeat (3) @(negedge clock);
      reset = 1'b0;
      check_bits("o_busy", busy, '0);
      check_bits("o_wr_take", wr_take, '0);
      check_bits("o_cmd_error", chan_bits_t'(cmd_error), '0);
      check_bits("o_rc_ready", chan_bits_t'(rc_ready), '0);
      check_bits("o_tx_valid", chan_bits_t'(tx_valid), '0);

      send_rc(32'h0001_2300, 32'hA1B2_C3D4);
      wait_idle("completion");
      check_count("o_rc_ready pulses", rc_pulses, 1);

      send_cmd(0, 1'b0, 64'h0000_0000_8000_1000, 3, 1'b0);  // 3-dword reads
      wait_idle("read 32-bit");
      send_cmd(2, 1'b0, 64'h0000_0001_2000_0000, 2, 1'b0);
      wait_idle("read 64-bit");

      send_cmd(1, 1'b1, 64'h0000_0000_4000_0040, 1, 1'b0);  // shifted payload
      wait_idle("write 32-bit");
      send_cmd(3, 1'b1, 64'h0000_00F0_0000_0080, 2, 1'b0);
      wait_idle("write 64-bit");

      send_cmd(0, 1'b1, 64'h0000_0000_1000_0000, 2, 1'b0);
      send_cmd(1, 1'b0, 64'h0000_0002_0000_0400, 3, 1'b0);
      send_cmd(2, 1'b1, 64'h0000_0003_0000_0000, 1, 1'b0);
      send_cmd(3, 1'b0, 64'h0000_0000_2000_0000, 4, 1'b0);
      wait_idle("all channels");

      send_cmd(1, 1'b0, 64'h0000_0000_9000_0000, 2, 1'b0);
      send_cmd(1, 1'b1, 64'h0000_0000_9100_0000, 1, 1'b1);  // channel still busy
      wait_idle("busy channel");

      random_ready = 1'b1;
      send_cmd(0, 1'b0, 64'h0000_0004_0000_0200, 3, 1'b0);
      send_cmd(1, 1'b1, 64'h0000_0000_5000_0000, 3, 1'b0);
      send_cmd(2, 1'b1, 64'h0000_0005_0000_0100, 2, 1'b0);
      send_cmd(3, 1'b0, 64'h0000_0000_6000_0000, 5, 1'b0);
      send_rc(32'h0004_5600, 32'h0F1E_2D3C);
      wait_idle("random ready");
      check_count("o_rc_ready pulses", rc_pulses, 2);

      // nothing may follow once every job is done
      for (int n = 0; n < 50; n++)
      begin
         @(negedge clock);
         if (tx_valid)
            fail_now("o_tx_valid rose after every expected TLP was seen");
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

/* pcie_tx_top.f */
+incdir+.
pcie_tx_pkg.sv
dma_cmd_demux.sv
dma_channel.sv
request_arbiter.sv
tlp_formatter.sv
fwft_fifo.sv
pcie_tx_top.sv
tb_pcie_tx_top.sv
